// File: hw/icache_geom_pkg.sv
/*
  Geometry of the instruction cache.
  Line size, set count and way count must be powers of two.
  Fetches are 32-bit aligned and the two low address bits are ignored.
  The memory port is one line wide, so a refill is a single beat.
*/
package icache_geom_pkg;

  ////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////

  // physical fetch address, no translation in front of the cache
  localparam int ADDR_BITS  = 32;
  // one instruction word per fetch
  localparam int FETCH_BITS = 32;

  ////////////////////////////////////////
  // array organisation
  ////////////////////////////////////////

  localparam int LINE_BYTES = 16;
  localparam int NUM_SETS   = 64;
  localparam int NUM_WAYS   = 4;

  // derived field widths
  localparam int LINE_BITS      = LINE_BYTES * 8;
  localparam int OFFSET_BITS    = $clog2(LINE_BYTES);
  localparam int INDEX_BITS     = $clog2(NUM_SETS);
  localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int WAY_BITS       = $clog2(NUM_WAYS);
  // word position inside a line
  localparam int WORD_BITS      = $clog2(LINE_BITS / FETCH_BITS);
  // tag and index together, the address of a whole line
  localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

  ////////////////////////////////////////
  // victim selection
  ////////////////////////////////////////

  // 8-bit galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
  localparam logic [7:0] LFSR_SEED = 8'hA5;
  localparam logic [7:0] LFSR_TAPS = 8'hB8;

endpackage

// File: hw/icache_types_pkg.sv
/*
  Packed structs passed between the cache stages and to the memory port.
  Field widths follow the geometry package.
  The Wishbone port is read only, so there is no we, sel or write data.
*/
package icache_types_pkg;
  import icache_geom_pkg::*;

  // fetch request and response, the response has no back-pressure
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [FETCH_BITS-1:0] data;
  } fetch_rsp_t;

  // one tag RAM entry, valid bit on top
  typedef struct packed {
    logic                valid;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  // one data RAM entry
  typedef struct packed {
    logic [LINE_BITS-1:0] data;
  } line_t;

  // stage 1 to stage 2
  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic [WORD_BITS-1:0]  offset;
    // low when the cache was disabled at accept time
    logic                  compare;
  } lookup_t;

  // stage 2 to stage 3
  typedef struct packed {
    logic [LINE_ADDR_BITS-1:0] line_addr;
    logic [NUM_WAYS-1:0]       way;
    // write the line back into the arrays
    logic                      allocate;
  } miss_t;

  // wishbone classic, master side
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic [ADDR_BITS-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    line_t dat;
  } wb_rsp_t;

  // line write into the way RAMs, one-hot way select
  typedef struct packed {
    logic                  we;
    logic [INDEX_BITS-1:0] index;
    logic [NUM_WAYS-1:0]   way;
  } ram_wr_t;

endpackage

// File: hw/icache_way_ram.sv
/*
  Synchronous single-port RAM for one cache way.
  Read data appears one cycle after rd_en_i and holds until the next read.
  A write to the address being read returns the new entry (write first).
  No reset, contents are undefined until the flush has run.
*/
`timescale 1ns/1ps

module icache_way_ram
  import icache_geom_pkg::*;
#(
  parameter type entry_t     = logic,
  parameter int  NUM_ENTRIES = NUM_SETS
) (
  input  logic                  clk_i,
  input  logic                  rd_en_i,
  input  logic [INDEX_BITS-1:0] rd_index_i,
  input  logic                  wr_en_i,
  input  logic [INDEX_BITS-1:0] wr_index_i,
  input  entry_t                wr_data_i,
  output entry_t                rd_data_o
);

  // storage, one entry per set
  entry_t mem_q [NUM_ENTRIES];

  always_ff @(posedge clk_i) begin : p_write
    if (wr_en_i) begin
      mem_q[wr_index_i] <= wr_data_i;
    end
  end

  // registered read port
  always_ff @(posedge clk_i) begin : p_read
    if (rd_en_i) begin
      // bypass so a same-cycle write is seen
      if (wr_en_i && (wr_index_i == rd_index_i)) begin
        rd_data_o <= wr_data_i;
      end else begin
        rd_data_o <= mem_q[rd_index_i];
      end
    end
  end

endmodule

// File: hw/icache_lookup.sv
/*
  Stage 1 of the instruction cache.
  Accepts fetches, splits the address and reads the way RAMs.
  Owns cache enable and flush: after reset, on flush_i and on a rising
  en_i all valid bits are cleared, which takes NUM_SETS cycles.
  A flush waits until no fetch is in flight or open as a miss.
*/
`timescale 1ns/1ps

module icache_lookup
  import icache_geom_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_i,
  input  logic                  flush_i,
  input  logic                  fetch_valid_i,
  input  fetch_req_t            fetch_req_i,
  output logic                  fetch_ready_o,
  input  logic                  refill_done_i,
  input  logic                  miss_valid_i,
  output lookup_t               lookup_o,
  output logic                  lookup_valid_o,
  output logic                  enabled_o,
  output logic                  rd_en_o,
  output logic [INDEX_BITS-1:0] rd_index_o,
  output ram_wr_t               flush_wr_o
);

  typedef enum logic [1:0] {
    FLUSH,
    RUN,
    WAIT_MISS
  } state_e;

  state_e                state_d, state_q;
  logic                  en_d, en_q;
  logic                  flush_pend_d, flush_pend_q;
  logic [INDEX_BITS-1:0] flush_cnt_q;
  logic                  flush_done;
  logic                  flush_req;
  logic                  pipe_idle;
  logic                  accept;
  lookup_t               lookup_q;
  logic                  valid_q;

  ////////////////////////////////////////
  // fetch handshake
  ////////////////////////////////////////

  // any reason to clear the arrays, including a fresh enable
  assign flush_req  = flush_pend_q | flush_i | (en_i & ~en_q);
  // a hit in stage 2 can still finish while the flush runs
  assign pipe_idle  = ~valid_q & ~miss_valid_i;
  assign flush_done = (flush_cnt_q == INDEX_BITS'(NUM_SETS - 1));

  // miss_valid_i is live in the compare cycle, so ready drops at once
  assign fetch_ready_o = (state_q == RUN) & ~miss_valid_i & ~flush_req;
  assign accept        = fetch_valid_i & fetch_ready_o;

  // an item behind a miss waits here and re-reads the arrays after the refill
  assign lookup_valid_o = valid_q & ~miss_valid_i;
  assign lookup_o       = lookup_q;
  // disabled fetches skip the array read
  assign rd_en_o        = lookup_valid_o & lookup_q.compare;
  assign rd_index_o     = lookup_q.index;
  assign enabled_o      = en_q;

  // flush writes an invalid entry into every way of one set per cycle
  assign flush_wr_o.we    = (state_q == FLUSH);
  assign flush_wr_o.index = flush_cnt_q;
  assign flush_wr_o.way   = '1;

  ////////////////////////////////////////
  // enable and flush control
  ////////////////////////////////////////

  always_comb begin : p_fsm
    state_d      = state_q;
    // disabling takes effect at once, enabling goes through a flush
    en_d         = en_q & en_i;
    flush_pend_d = flush_pend_q | flush_i;

    unique case (state_q)
      FLUSH: begin
        if (flush_done) begin
          state_d      = RUN;
          en_d         = en_i;
          flush_pend_d = flush_i;
        end
      end
      RUN: begin
        if (flush_req && pipe_idle) begin
          state_d = FLUSH;
        end else if (miss_valid_i) begin
          state_d = WAIT_MISS;
        end
      end
      WAIT_MISS: begin
        // ready rises in the cycle the response goes out
        if (refill_done_i) begin
          state_d = RUN;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q      <= FLUSH;
      en_q         <= 1'b0;
      flush_pend_q <= 1'b0;
      flush_cnt_q  <= '0;
      valid_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      en_q         <= en_d;
      flush_pend_q <= flush_pend_d;
      // wraps back to zero on the last set
      if (state_q == FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      // hold the item while stage 2 is busy with a miss
      valid_q <= accept | (valid_q & miss_valid_i);
    end
  end

  // address split, captured on accept
  always_ff @(posedge clk_i) begin : p_payload
    if (accept) begin
      lookup_q.tag     <= fetch_req_i.addr[ADDR_BITS-1 -: TAG_BITS];
      lookup_q.index   <= fetch_req_i.addr[OFFSET_BITS +: INDEX_BITS];
      lookup_q.offset  <= fetch_req_i.addr[OFFSET_BITS-1 -: WORD_BITS];
      lookup_q.compare <= en_q;
    end
  end

endmodule

// File: hw/icache_hit_select.sv
/*
  Stage 2 of the instruction cache.
  Compares the registered tags of all ways and selects the hit word.
  On a miss it picks a victim: the lowest invalid way, else an LFSR way.
  miss_valid_o is combinational in the compare cycle and then held until
  refill_done_i, which also loads the response from the refill line.
*/
`timescale 1ns/1ps

module icache_hit_select
  import icache_geom_pkg::*;
  import icache_types_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  lookup_t                   lookup_i,
  input  logic                      lookup_valid_i,
  input  logic                      enabled_i,
  input  tag_entry_t [NUM_WAYS-1:0] tags_i,
  input  line_t      [NUM_WAYS-1:0] lines_i,
  input  line_t                     refill_rsp_i,
  input  logic                      refill_done_i,
  output miss_t                     miss_o,
  output logic                      miss_valid_o,
  output fetch_rsp_t                fetch_rsp_o,
  output logic                      fetch_rsp_valid_o
);

  lookup_t               lk_q;
  logic                  lk_valid_q;
  logic                  miss_open_q;
  miss_t                 miss_q, miss_new;
  logic [7:0]            lfsr_q;
  fetch_rsp_t            rsp_q;
  logic                  rsp_valid_q;
  logic [NUM_WAYS-1:0]   hit_oh, inv_oh, rnd_oh;
  logic                  hit, all_valid, miss_now;
  logic [FETCH_BITS-1:0] hit_word;

  ////////////////////////////////////////
  // tag compare and word select
  ////////////////////////////////////////

  always_comb begin : p_compare
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_oh[w] = lk_q.compare & tags_i[w].valid & (tags_i[w].tag == lk_q.tag);
      // at most one way hits, so an or-mux is enough
      if (hit_oh[w]) begin
        hit_word |= lines_i[w].data[lk_q.offset*FETCH_BITS +: FETCH_BITS];
      end
    end
  end

  assign hit      = |hit_oh;
  assign miss_now = lk_valid_q & ~hit;

  ////////////////////////////////////////
  // victim choice
  ////////////////////////////////////////

  // scan downwards so the lowest invalid way wins
  always_comb begin : p_first_invalid
    inv_oh = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!tags_i[w].valid) begin
        inv_oh = NUM_WAYS'(1) << w;
      end
    end
  end

  assign all_valid = (inv_oh == '0);
  assign rnd_oh    = NUM_WAYS'(1) << lfsr_q[WAY_BITS-1:0];

  assign miss_new.line_addr = {lk_q.tag, lk_q.index};
  assign miss_new.way       = all_valid ? rnd_oh : inv_oh;
  // no allocation for fetches made with the cache off
  assign miss_new.allocate  = lk_q.compare & enabled_i;

  // stage 3 takes the live item in the compare cycle, the copy afterwards
  assign miss_o       = miss_open_q ? miss_q : miss_new;
  assign miss_valid_o = miss_now | miss_open_q;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      lk_valid_q  <= 1'b0;
      miss_open_q <= 1'b0;
      lfsr_q      <= LFSR_SEED;
      rsp_valid_q <= 1'b0;
    end else begin
      lk_valid_q <= lookup_valid_i;
      if (miss_now) begin
        miss_open_q <= 1'b1;
      end else if (refill_done_i) begin
        miss_open_q <= 1'b0;
      end
      // galois step once per allocating miss
      if (miss_now && miss_new.allocate) begin
        lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 8'h00);
      end
      rsp_valid_q <= (lk_valid_q & hit) | refill_done_i;
    end
  end

  // lk_q stays put during a miss, stage 1 holds back the next item
  always_ff @(posedge clk_i) begin : p_payload
    if (lookup_valid_i) begin
      lk_q <= lookup_i;
    end
    if (miss_now) begin
      miss_q <= miss_new;
    end
    if (lk_valid_q && hit) begin
      rsp_q.data <= hit_word;
    end else if (refill_done_i) begin
      rsp_q.data <= refill_rsp_i.data[lk_q.offset*FETCH_BITS +: FETCH_BITS];
    end
  end

  assign fetch_rsp_o       = rsp_q;
  assign fetch_rsp_valid_o = rsp_valid_q;

endmodule

// File: hw/icache_refill.sv
/*
  Stage 3 of the instruction cache, a Wishbone classic read master.
  One cycle per miss, cyc and stb stay high until ack and fall on the next
  edge. The whole line arrives in that single beat.
  miss_i must stay stable from miss_valid_i until refill_done_o.
*/
`timescale 1ns/1ps

module icache_refill
  import icache_geom_pkg::*;
  import icache_types_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  miss_t   miss_i,
  input  logic    miss_valid_i,
  output wb_req_t wb_req_o,
  input  wb_rsp_t wb_rsp_i,
  output ram_wr_t refill_wr_o,
  output line_t   refill_line_o,
  output logic    refill_done_o,
  output logic    miss_count_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } state_e;

  state_e state_q;
  line_t  line_q;
  logic   count_q;

  ////////////////////////////////////////
  // bus cycle control
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fsm
    if (!rst_ni) begin
      state_q <= IDLE;
      count_q <= 1'b0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (miss_valid_i) begin
            state_q <= BUSY;
          end
        end
        BUSY: begin
          // a late ack just keeps the cycle open
          if (wb_rsp_i.ack) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
      // counter pulse lines up with cyc rising, cacheable misses only
      count_q <= (state_q == IDLE) & miss_valid_i & miss_i.allocate;
    end
  end

  // returned line, sampled with ack
  always_ff @(posedge clk_i) begin : p_line
    if ((state_q == BUSY) && wb_rsp_i.ack) begin
      line_q <= wb_rsp_i.dat;
    end
  end

  // read only master, address is line aligned
  assign wb_req_o.cyc = (state_q == BUSY);
  assign wb_req_o.stb = (state_q == BUSY);
  assign wb_req_o.adr = {miss_i.line_addr, {OFFSET_BITS{1'b0}}};

  ////////////////////////////////////////
  // array write and completion
  ////////////////////////////////////////

  // write the victim way in the cycle after ack
  assign refill_wr_o.we    = (state_q == DONE) & miss_i.allocate;
  assign refill_wr_o.index = miss_i.line_addr[INDEX_BITS-1:0];
  assign refill_wr_o.way   = miss_i.way;

  assign refill_line_o = line_q;
  assign refill_done_o = (state_q == DONE);
  assign miss_count_o  = count_q;

endmodule

// File: hw/icache_top.sv
/*
  Set-associative instruction cache with a blocking refill.
  Hits answer 2 cycles after accept, one fetch per cycle.
  Misses go out as one Wishbone classic read of a whole line.
  The fetch response has no back-pressure.
*/
`timescale 1ns/1ps

module icache_top
  import icache_geom_pkg::*;
  import icache_types_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       flush_i,
  input  logic       fetch_valid_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output logic       fetch_rsp_valid_o,
  output fetch_rsp_t fetch_rsp_o,
  output wb_req_t    wb_req_o,
  input  wb_rsp_t    wb_rsp_i,
  output logic       miss_o
);

  lookup_t                   lookup;
  logic                      lookup_valid;
  logic                      enabled;
  logic                      rd_en;
  logic [INDEX_BITS-1:0]     rd_index;
  ram_wr_t                   flush_wr, refill_wr, wr;
  miss_t                     miss;
  logic                      miss_valid;
  line_t                     refill_line;
  logic                      refill_done;
  tag_entry_t [NUM_WAYS-1:0] tag_rd;
  line_t      [NUM_WAYS-1:0] line_rd;
  tag_entry_t                tag_wdata;

  ////////////////////////////////////////
  // pipeline stages
  ////////////////////////////////////////

  icache_lookup icache_lookup_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .refill_done_i (refill_done),
    .miss_valid_i  (miss_valid),
    .lookup_o      (lookup),
    .lookup_valid_o(lookup_valid),
    .enabled_o     (enabled),
    .rd_en_o       (rd_en),
    .rd_index_o    (rd_index),
    .flush_wr_o    (flush_wr)
  );

  icache_hit_select icache_hit_select_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lookup_i         (lookup),
    .lookup_valid_i   (lookup_valid),
    .enabled_i        (enabled),
    .tags_i           (tag_rd),
    .lines_i          (line_rd),
    .refill_rsp_i     (refill_line),
    .refill_done_i    (refill_done),
    .miss_o           (miss),
    .miss_valid_o     (miss_valid),
    .fetch_rsp_o      (fetch_rsp_o),
    .fetch_rsp_valid_o(fetch_rsp_valid_o)
  );

  icache_refill icache_refill_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_i       (miss),
    .miss_valid_i (miss_valid),
    .wb_req_o     (wb_req_o),
    .wb_rsp_i     (wb_rsp_i),
    .refill_wr_o  (refill_wr),
    .refill_line_o(refill_line),
    .refill_done_o(refill_done),
    .miss_count_o (miss_o)
  );

  ////////////////////////////////////////
  // way arrays
  ////////////////////////////////////////

  // flush and refill writes never overlap
  assign wr              = flush_wr.we ? flush_wr : refill_wr;
  // flush clears the valid bit, the tag itself does not matter then
  assign tag_wdata.valid = ~flush_wr.we;
  assign tag_wdata.tag   = miss.line_addr[LINE_ADDR_BITS-1 -: TAG_BITS];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    icache_way_ram #(
      .entry_t    (tag_entry_t),
      .NUM_ENTRIES(NUM_SETS)
    ) tag_ram_inst (
      .clk_i     (clk_i),
      .rd_en_i   (rd_en),
      .rd_index_i(rd_index),
      .wr_en_i   (wr.we & wr.way[w]),
      .wr_index_i(wr.index),
      .wr_data_i (tag_wdata),
      .rd_data_o (tag_rd[w])
    );

    // data is only written by a refill
    icache_way_ram #(
      .entry_t    (line_t),
      .NUM_ENTRIES(NUM_SETS)
    ) data_ram_inst (
      .clk_i     (clk_i),
      .rd_en_i   (rd_en),
      .rd_index_i(rd_index),
      .wr_en_i   (refill_wr.we & refill_wr.way[w]),
      .wr_index_i(refill_wr.index),
      .wr_data_i (refill_line),
      .rd_data_o (line_rd[w])
    );
  end

endmodule

// File: tests/tb_icache.sv
/*
  Testbench for the instruction cache.
  Fetches are driven on the falling edge, responses are checked in order
  against a reference word function, with the hit latency of 2 cycles.
  The Wishbone model answers each cycle after 0 to 7 cycles.
  The run stops at the first failing check.
*/
`timescale 1ns/1ps

module tb_icache
  import icache_geom_pkg::*;
  import icache_types_pkg::*;
();

  localparam int          TIMEOUT_CYCLES = 400;
  localparam logic [31:0] LFSR_INIT      = 32'h1c0c5333;
  localparam logic [31:0] LFSR_MASK      = 32'h80200003;
  localparam logic [1:0]  KIND_ANY       = 2'd0;
  localparam logic [1:0]  KIND_HIT       = 2'd1;
  localparam logic [1:0]  KIND_MISS      = 2'd2;

  // one accepted fetch waiting for its response
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] cycle;
    logic [1:0]  kind;
  } expect_t;

  logic       clk_i;
  logic       rst_ni;
  logic       en_i;
  logic       flush_i;
  logic       fetch_valid_i;
  fetch_req_t fetch_req_i;
  logic       fetch_ready_o;
  logic       fetch_rsp_valid_o;
  fetch_rsp_t fetch_rsp_o;
  wb_req_t    wb_req_o;
  wb_rsp_t    wb_rsp_i = '0;
  logic       miss_o;

  logic [31:0] lfsr        = LFSR_INIT;
  logic [31:0] cycle_cnt   = '0;
  logic        mem_busy    = 1'b0;
  int          mem_wait    = 0;
  int          wb_cycles   = 0;
  int          miss_pulses = 0;
  int          rsp_hits    = 0;
  int          rsp_misses  = 0;
  int          fail_count  = 0;
  string       test_name   = "reset";
  expect_t     pending_q[$];

  icache_top icache_top_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_i             (en_i),
    .flush_i          (flush_i),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_req_i      (fetch_req_i),
    .fetch_ready_o    (fetch_ready_o),
    .fetch_rsp_valid_o(fetch_rsp_valid_o),
    .fetch_rsp_o      (fetch_rsp_o),
    .wb_req_o         (wb_req_o),
    .wb_rsp_i         (wb_rsp_i),
    .miss_o           (miss_o)
  );

  ////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////

  // word at an address, rotated left by address bits 8 to 4
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [31:0] base;
    logic [63:0] twice;
    base  = {addr[31:2], 2'b00} ^ 32'h5a5a0000;
    twice = {base, base} << addr[8:4];
    return twice[63:32];
  endfunction

  // word i of the line sits at bits 32*i and up
  function automatic line_t build_line(input logic [31:0] adr);
    line_t line;
    for (int i = 0; i < LINE_BITS / FETCH_BITS; i++) begin
      line.data[i*FETCH_BITS +: FETCH_BITS] = ref_word(adr + 32'(i * 4));
    end
    return line;
  endfunction

  function automatic logic [31:0] galois_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_MASK) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int count, output logic [7:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
      bits[i] = lfsr[0];
      lfsr    = galois_step(lfsr);
    end
  endtask

  // five lines of set 5, word offset varies with the line
  function automatic logic [31:0] same_set_addr(input int line);
    return 32'((line + 1) * 1024 + 5 * 16 + (line % 4) * 4);
  endfunction

  task automatic stop_run();
    fail_count++;
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_failure(input string msg);
    $display("error in %s: %s", test_name, msg);
    stop_run();
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // clock, cycle count, memory model
  ////////////////////////////////////////

  initial begin : p_clock
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  always @(posedge clk_i) begin : p_cycles
    cycle_cnt <= cycle_cnt + 1;
  end

  // wishbone classic slave, one beat per cycle, random ack delay
  always @(negedge clk_i) begin : p_memory
    logic [7:0] delay;
    if (!rst_ni) begin
      wb_rsp_i = '0;
      mem_busy = 1'b0;
    end else if (wb_rsp_i.ack) begin
      // cyc must have fallen on the ack edge
      if (wb_req_o.cyc) begin
        report_failure("cyc still high after ack");
      end
      wb_rsp_i.ack = 1'b0;
    end else if (wb_req_o.cyc && wb_req_o.stb) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        wb_cycles++;
        draw_bits(3, delay);
        mem_wait = delay;
        check_value("line aligned address", 32'd0, 32'(wb_req_o.adr[OFFSET_BITS-1:0]));
      end
      if (mem_wait == 0) begin
        wb_rsp_i.ack = 1'b1;
        wb_rsp_i.dat = build_line(wb_req_o.adr);
        mem_busy     = 1'b0;
      end else begin
        mem_wait--;
      end
    end
  end

  ////////////////////////////////////////
  // response compare
  ////////////////////////////////////////

  always @(negedge clk_i) begin : p_compare
    expect_t     item;
    logic [31:0] latency;
    if (rst_ni) begin
      if (miss_o) begin
        miss_pulses++;
      end
      if (fetch_rsp_valid_o) begin
        if (pending_q.size() == 0) begin
          report_failure("response without a pending fetch");
        end else begin
          item    = pending_q.pop_front();
          latency = cycle_cnt - item.cycle;
          check_value($sformatf("data at %h", item.addr), ref_word(item.addr),
                      fetch_rsp_o.data);
          // a hit is the only case with latency 2
          if (latency == 32'd2) begin
            rsp_hits++;
          end else begin
            rsp_misses++;
          end
          if (item.kind == KIND_HIT) begin
            check_value("hit latency", 32'd2, latency);
          end else if ((item.kind == KIND_MISS) && (latency == 32'd2)) begin
            report_failure($sformatf("fetch of %h hit but should miss", item.addr));
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // fetch driver
  ////////////////////////////////////////

  // leaves valid high, so the next call gives a back-to-back fetch
  task automatic issue_fetch(input logic [31:0] addr, input logic [1:0] kind,
                             output logic [31:0] acc_cycle);
    int      waited;
    expect_t item;
    waited = 0;
    @(negedge clk_i);
    fetch_valid_i    = 1'b1;
    fetch_req_i.addr = addr;
    // ready only depends on registers and inputs set at the falling edge
    #1;
    while (!fetch_ready_o) begin
      if (waited == TIMEOUT_CYCLES) begin
        report_failure($sformatf("fetch of %h was never accepted", addr));
      end else begin
        waited++;
        @(negedge clk_i);
        #1;
      end
    end
    acc_cycle  = cycle_cnt + 1;
    item.addr  = addr;
    item.cycle = acc_cycle;
    item.kind  = kind;
    pending_q.push_back(item);
  endtask

  task automatic release_fetch();
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
    fetch_req_i   = '0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (pending_q.size() != 0) begin
      if (waited == TIMEOUT_CYCLES) begin
        report_failure("fetch response never arrived");
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
  endtask

  task automatic fetch_one(input logic [31:0] addr, input logic [1:0] kind);
    logic [31:0] acc_cycle;
    issue_fetch(addr, kind, acc_cycle);
    release_fetch();
    wait_responses();
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : p_main
    logic [31:0] acc [4];
    int          wb_start;
    int          miss_start;
    int          hit_start;
    int          rsp_start;
    rst_ni        = 1'b0;
    en_i          = 1'b1;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_req_i   = '0;
    repeat (5) @(negedge clk_i);
    check_value("ready in reset", 32'd0, 32'(fetch_ready_o));
    check_value("response valid in reset", 32'd0, 32'(fetch_rsp_valid_o));
    check_value("cyc and stb in reset", 32'd0, 32'({wb_req_o.cyc, wb_req_o.stb}));
    check_value("miss pulse in reset", 32'd0, 32'(miss_o));
    rst_ni = 1'b1;

    // cold lines in sets 0 to 3, one wishbone cycle and one miss pulse each
    test_name = "cold fetch";
    for (int i = 0; i < 4; i++) begin
      wb_start   = wb_cycles;
      miss_start = miss_pulses;
      fetch_one(32'h0000_1000 * (i + 1) + 32'(i * 20), KIND_MISS);
      check_value("wishbone cycles", 32'(wb_start + 1), 32'(wb_cycles));
      check_value("miss pulses", 32'(miss_start + 1), 32'(miss_pulses));
    end

    // hits, then four on consecutive cycles
    test_name  = "hit";
    wb_start   = wb_cycles;
    miss_start = miss_pulses;
    fetch_one(32'h0000_1008, KIND_HIT);
    for (int i = 0; i < 4; i++) begin
      issue_fetch(32'h0000_1000 * (i + 1) + 32'(i * 16 + (3 - i) * 4), KIND_HIT, acc[i]);
    end
    release_fetch();
    wait_responses();
    for (int i = 1; i < 4; i++) begin
      check_value("accept cycle", acc[i-1] + 1, acc[i]);
    end
    check_value("wishbone cycles", 32'(wb_start), 32'(wb_cycles));
    check_value("miss pulses", 32'(miss_start), 32'(miss_pulses));

    // five lines in set 5, the fifth evicts one way
    test_name  = "same set";
    wb_start   = wb_cycles;
    miss_start = miss_pulses;
    rsp_start  = rsp_misses;
    for (int i = 0; i < 5; i++) begin
      fetch_one(same_set_addr(i), KIND_MISS);
    end
    hit_start = rsp_hits;
    for (int i = 0; i < 4; i++) begin
      fetch_one(same_set_addr(i), KIND_ANY);
    end
    // one of the first four lines was evicted by the fifth
    if (rsp_hits - hit_start > NUM_WAYS - 1) begin
      report_failure("more hits than lines still cached");
    end
    check_value("wishbone cycles", 32'(rsp_misses - rsp_start), 32'(wb_cycles - wb_start));
    check_value("miss pulses", 32'(rsp_misses - rsp_start), 32'(miss_pulses - miss_start));

    // a flush drops the line cached by the cold test
    test_name = "flush";
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i    = 1'b0;
    wb_start   = wb_cycles;
    miss_start = miss_pulses;
    fetch_one(32'h0000_1000, KIND_MISS);
    check_value("wishbone cycles", 32'(wb_start + 1), 32'(wb_cycles));
    check_value("miss pulses", 32'(miss_start + 1), 32'(miss_pulses));

    // disabled cache fetches through memory and allocates nothing
    test_name = "disabled";
    @(negedge clk_i);
    en_i       = 1'b0;
    wb_start   = wb_cycles;
    miss_start = miss_pulses;
    fetch_one(32'h0000_1000, KIND_MISS);
    fetch_one(32'h0000_1000, KIND_MISS);
    fetch_one(32'h0000_5044, KIND_MISS);
    check_value("wishbone cycles", 32'(wb_start + 3), 32'(wb_cycles));
    check_value("miss pulses", 32'(miss_start), 32'(miss_pulses));

    // enabling flushes, so the first fetch misses and the line then hits
    test_name = "re-enable";
    @(negedge clk_i);
    en_i       = 1'b1;
    wb_start   = wb_cycles;
    miss_start = miss_pulses;
    fetch_one(32'h0000_1000, KIND_MISS);
    fetch_one(32'h0000_100c, KIND_HIT);
    check_value("wishbone cycles", 32'(wb_start + 1), 32'(wb_cycles));
    check_value("miss pulses", 32'(miss_start + 1), 32'(miss_pulses));

    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/icache_geom_pkg.sv
hw/icache_types_pkg.sv
hw/icache_way_ram.sv
hw/icache_lookup.sv
hw/icache_hit_select.sv
hw/icache_refill.sv
hw/icache_top.sv
tests/tb_icache.sv
